// File: Makefile
# Verilator build and run for the serial LSU testbench.

VERILATOR ?= verilator
TOP       ?= tb_ser_lsu
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+24
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FILELIST := all.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a listed source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) $(SEED_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
design/ser_pkg.sv
design/ser_bit_counter.sv
design/ser_data_buf.sv
design/ser_mem_port.sv
design/ser_sequencer.sv
design/ser_lsu_top.sv
testbench/ser_lsu_assertions.sv
testbench/tb_ser_lsu.sv

// File: design/ser_bit_counter.sv
`timescale 1ns/10ps
`default_nettype none

module ser_bit_counter (
   input  wire logic         i_clk,
   input  wire logic         i_rst,
   input  wire logic         i_cnt_en,
   output ser_pkg::bytecnt_t o_bytecnt,
   output logic              o_cnt_done
);
   import ser_pkg::*;

   logic [CNT_W-1:0] cnt;   // serial bit index.

   // free count over one word, wraps after 31.
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt <= '0;
      end else if (i_cnt_en) begin
         cnt <= cnt + 1'b1;
      end
   end

   assign o_bytecnt = cnt[CNT_W-1 -: 2];   // top two bits give the byte.

   // last bit of the word, only while counting.
   assign o_cnt_done = i_cnt_en & (cnt == '1);

endmodule

`default_nettype wire

// File: design/ser_data_buf.sv
`timescale 1ns/10ps
`default_nettype none

module ser_data_buf (
   input  wire logic              i_clk,
   input  wire logic              i_en,
   input  wire logic              i_init,
   input  wire logic              i_cnt_done,
   input  wire logic              i_shift_op,
   input  wire logic              i_op_b_sel,
   input  wire logic              i_rs2,
   input  wire logic              i_imm,
   input  wire logic              i_load,
   input  wire ser_pkg::lsb_t     i_lsb,
   input  wire ser_pkg::bytecnt_t i_bytecnt,
   input  wire ser_pkg::word_t    i_dat,
   output logic                   o_sh_done,
   output logic                   o_op_b,
   output logic                   o_q,
   output ser_pkg::word_t         o_dat
);
   import ser_pkg::*;

   word_t      dat;          // one register, three uses.
   logic       byte_valid;   // lsb + bytecnt < 4.
   logic       dat_en;
   logic [5:0] dat_shamt;    // next value of the low six bits.

   // lsb + bytecnt < 4, spelled out as products.
   assign byte_valid = (~i_bytecnt[1] & ~i_bytecnt[0]) |
                       (~i_lsb[1]     & ~i_lsb[0])     |
                       (~i_lsb[1]     & ~i_bytecnt[1]) |
                       (~i_lsb[1]     & ~i_bytecnt[0]) |
                       (~i_lsb[0]     & ~i_bytecnt[1]);

   assign o_op_b = i_op_b_sel ? i_rs2 : i_imm;   // serial operand b.

   // shift ops run every cycle, stores and loads only in valid bytes.
   assign dat_en = i_shift_op | (i_en & byte_valid);

   // stores land rs2 in the addressed lanes, loads stream from the tap,
   // and shifts reuse the low six bits as a down counter.
   always_comb begin
      if (i_shift_op && !i_init) begin
         dat_shamt = dat[5:0] - 6'd1;   // count down.
      end else begin
         // plain shift, bit 5 cleared on the last init bit.
         dat_shamt = {dat[6] & ~(i_shift_op & i_cnt_done), dat[5:1]};
      end
   end

   assign o_sh_done = dat_shamt[5];   // wrap below zero.

   // read-out tap at the first addressed byte.
   assign o_q = dat[{i_lsb, 3'b000}];

   assign o_dat = dat;   // write data for the memory port.

   always_ff @(posedge i_clk) begin
      if (i_load) begin
         dat <= i_dat;   // latch read data on ack.
      end else if (dat_en) begin
         dat <= {o_op_b, dat[XLEN-1:7], dat_shamt};
      end
   end

endmodule

`default_nettype wire

// File: design/ser_lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module ser_lsu_top (
   input  wire logic            i_clk,
   input  wire logic            i_rst,
   input  wire logic            i_start,
   input  wire ser_pkg::cmd_t   i_cmd,
   input  wire logic            i_rs2,
   input  wire logic            i_imm,
   input  wire logic            i_mem_ack,
   input  wire ser_pkg::word_t  i_mem_rdata,
   output logic                 o_busy,
   output logic                 o_init,
   output logic                 o_run,
   output logic                 o_q,
   output logic                 o_done,
   output logic                 o_mem_req,
   output ser_pkg::mem_req_t    o_mem
);
   import ser_pkg::*;

   // sequencer controls.
   logic     cnt_en;
   logic     en;
   logic     shift_op;
   logic     op_b_sel;
   logic     bus_go;
   logic     we;
   lsb_t     lsb;
   size_e    size;

   // returns to the sequencer and buffer.
   bytecnt_t bytecnt;
   logic     cnt_done;
   logic     sh_done;
   logic     bus_done;
   logic     load;
   word_t    buf_dat;   // buffer contents, store write data.

   ser_sequencer u_seq (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .i_cmd      (i_cmd),
      .i_cnt_done (cnt_done),
      .i_sh_done  (sh_done),
      .i_bus_done (bus_done),
      .o_cnt_en   (cnt_en),
      .o_init     (o_init),
      .o_run      (o_run),
      .o_en       (en),
      .o_shift_op (shift_op),
      .o_op_b_sel (op_b_sel),
      .o_bus_go   (bus_go),
      .o_we       (we),
      .o_busy     (o_busy),
      .o_done     (o_done),
      .o_lsb      (lsb),
      .o_size     (size)
   );

   ser_bit_counter u_cnt (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_cnt_en   (cnt_en),
      .o_bytecnt  (bytecnt),
      .o_cnt_done (cnt_done)
   );

   // operand b feeds an ALU outside this slice.
   ser_data_buf u_buf (
      .i_clk      (i_clk),
      .i_en       (en),
      .i_init     (o_init),
      .i_cnt_done (cnt_done),
      .i_shift_op (shift_op),
      .i_op_b_sel (op_b_sel),
      .i_rs2      (i_rs2),
      .i_imm      (i_imm),
      .i_load     (load),
      .i_lsb      (lsb),
      .i_bytecnt  (bytecnt),
      .i_dat      (i_mem_rdata),
      .o_sh_done  (sh_done),
      .o_op_b     (),
      .o_q        (o_q),
      .o_dat      (buf_dat)
   );

   ser_mem_port u_mem (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_go       (bus_go),
      .i_we       (we),
      .i_lsb      (lsb),
      .i_size     (size),
      .i_wdata    (buf_dat),
      .i_mem_ack  (i_mem_ack),
      .o_mem_req  (o_mem_req),
      .o_mem      (o_mem),
      .o_bus_done (bus_done),
      .o_load     (load)
   );

endmodule

`default_nettype wire

// File: design/ser_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module ser_mem_port (
   input  wire logic            i_clk,
   input  wire logic            i_rst,
   input  wire logic            i_go,
   input  wire logic            i_we,
   input  wire ser_pkg::lsb_t   i_lsb,
   input  wire ser_pkg::size_e  i_size,
   input  wire ser_pkg::word_t  i_wdata,
   input  wire logic            i_mem_ack,
   output logic                 o_mem_req,
   output ser_pkg::mem_req_t    o_mem,
   output logic                 o_bus_done,
   output logic                 o_load
);
   import ser_pkg::*;

   logic req;        // request level.
   logic we_r;       // held for the whole access.
   sel_t sel_r;
   sel_t sel_base;   // lanes covered before the lsb shift.

   // lane mask by access size.
   always_comb begin
      case (i_size)
         SZ_BYTE: sel_base = 4'b0001;
         SZ_HALF: sel_base = 4'b0011;
         default: sel_base = 4'b1111;
      endcase
   end

   // raised by go, dropped by the ack.
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         req <= 1'b0;
      end else if (i_go) begin
         req <= 1'b1;
      end else if (i_mem_ack) begin
         req <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_go) begin
         we_r  <= i_we;
         sel_r <= sel_base << i_lsb;   // lanes start at the byte offset.
      end
   end

   assign o_mem_req = req;

   // buffer is frozen while the request is out.
   always_comb begin
      o_mem.we    = we_r;
      o_mem.sel   = sel_r;
      o_mem.wdata = i_wdata;
   end

   assign o_bus_done = req & i_mem_ack;    // ack cycle.
   assign o_load     = o_bus_done & ~we_r;  // only reads fill the buffer.

endmodule

`default_nettype wire

// File: design/ser_pkg.sv
`default_nettype none

package ser_pkg;

   localparam int XLEN  = 32;   // data word width.
   localparam int CNT_W = 5;    // serial bit index, 0 to 31.

   // widths with a meaning of their own.
   typedef logic [XLEN-1:0] word_t;
   typedef logic [1:0]      lsb_t;       // byte offset of the address.
   typedef logic [1:0]      bytecnt_t;   // byte now on the serial wire.
   typedef logic [3:0]      sel_t;       // one bit per byte lane.

   typedef enum logic [1:0] {
      OP_LOAD  = 2'd0,
      OP_STORE = 2'd1,
      OP_SHIFT = 2'd2
   } op_e;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   // sequencer phases.
   typedef enum logic [2:0] {
      S_IDLE  = 3'd0,
      S_INIT  = 3'd1,   // operands shift in.
      S_BUS   = 3'd2,   // memory request pending.
      S_RUN   = 3'd3,   // load data shifts out.
      S_COUNT = 3'd4,   // shift amount counts down.
      S_DONE  = 3'd5
   } seq_state_e;

   typedef struct packed {
      op_e   op;
      lsb_t  lsb;
      size_e size;
      logic  b_sel;     // 1 takes rs2, 0 takes imm.
   } cmd_t;

   typedef struct packed {
      logic  we;
      sel_t  sel;
      word_t wdata;
   } mem_req_t;

endpackage

`default_nettype wire

// File: design/ser_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module ser_sequencer (
   input  wire logic            i_clk,
   input  wire logic            i_rst,
   input  wire logic            i_start,
   input  wire ser_pkg::cmd_t   i_cmd,
   input  wire logic            i_cnt_done,
   input  wire logic            i_sh_done,
   input  wire logic            i_bus_done,
   output logic                 o_cnt_en,
   output logic                 o_init,
   output logic                 o_run,
   output logic                 o_en,
   output logic                 o_shift_op,
   output logic                 o_op_b_sel,
   output logic                 o_bus_go,
   output logic                 o_we,
   output logic                 o_busy,
   output logic                 o_done,
   output ser_pkg::lsb_t        o_lsb,
   output ser_pkg::size_e       o_size
);
   import ser_pkg::*;

   seq_state_e state;
   seq_state_e state_nxt;
   cmd_t       cmd_r;     // command of the running op.
   cmd_t       cur_cmd;   // live command while idle, latched after.
   logic       is_store;
   logic       is_shift;

   always_ff @(posedge i_clk) begin
      if (i_start && state == S_IDLE) begin
         cmd_r <= i_cmd;
      end
   end

   // a load goes to the bus in the start cycle, so it needs i_cmd.
   assign cur_cmd  = (state == S_IDLE) ? i_cmd : cmd_r;
   assign is_store = (cmd_r.op == OP_STORE);
   assign is_shift = (cmd_r.op == OP_SHIFT);

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (i_start) begin
               state_nxt = (i_cmd.op == OP_LOAD) ? S_BUS : S_INIT;
            end
         end
         S_INIT: begin
            if (i_cnt_done) begin
               state_nxt = is_shift ? S_COUNT : S_BUS;
            end
         end
         S_BUS: begin
            if (i_bus_done) begin
               state_nxt = is_store ? S_DONE : S_RUN;   // loads stream out.
            end
         end
         S_RUN: begin
            if (i_cnt_done) state_nxt = S_DONE;
         end
         S_COUNT: begin
            if (i_sh_done) state_nxt = S_DONE;   // shift amount used up.
         end
         S_DONE:  state_nxt = S_IDLE;
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= S_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign o_init   = (state == S_INIT);
   assign o_run    = (state == S_RUN);
   assign o_cnt_en = o_init | o_run;   // counter runs in both serial phases.

   // lane-gated shifting for store init and load run.
   assign o_en = (o_init & ~is_shift) | o_run;

   // shift ops shift in during init and count afterwards.
   assign o_shift_op = is_shift & (o_init | (state == S_COUNT));
   assign o_op_b_sel = cmd_r.b_sel;

   // load request at start, store request on the last init bit.
   assign o_bus_go = ((state == S_IDLE) & i_start & (i_cmd.op == OP_LOAD)) |
                     (o_init & i_cnt_done & is_store);

   assign o_we   = (cur_cmd.op == OP_STORE);
   assign o_lsb  = cur_cmd.lsb;
   assign o_size = cur_cmd.size;

   assign o_busy = (state != S_IDLE);
   assign o_done = (state == S_DONE);   // single-cycle pulse.

endmodule

`default_nettype wire

// File: testbench/ser_lsu_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module ser_lsu_assertions (
   input wire logic              i_clk,
   input wire logic              i_rst,
   input wire logic              i_busy,
   input wire logic              i_init,
   input wire logic              i_run,
   input wire logic              i_done,
   input wire logic              i_mem_req,
   input wire logic              i_mem_ack,
   input wire ser_pkg::mem_req_t i_mem
);

   // request is a level, only the ack drops it.
   req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_mem_req && !i_mem_ack) |=> (i_mem_req && $stable(i_mem)))
      else $error("memory request dropped or changed before its ack");

   done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
      i_done |=> !i_done)   // single cycle.
      else $error("done stayed high for more than one cycle");

   // serial phases, done and a bus access never overlap.
   phase_excl: assert property (@(posedge i_clk) disable iff (i_rst)
      $onehot0({i_init, i_run, i_done, i_mem_req}))
      else $error("serial phase, done or memory request high together");

   // sync reset clears every control output.
   reset_quiet: assert property (@(posedge i_clk)
      i_rst |=> !(i_busy || i_init || i_run || i_done || i_mem_req))
      else $error("control outputs not low after reset");

endmodule

bind ser_lsu_top ser_lsu_assertions u_assertions (
   .i_clk     (i_clk),
   .i_rst     (i_rst),
   .i_busy    (o_busy),
   .i_init    (o_init),
   .i_run     (o_run),
   .i_done    (o_done),
   .i_mem_req (o_mem_req),
   .i_mem_ack (i_mem_ack),
   .i_mem     (o_mem)
);

`default_nettype wire

// File: testbench/ser_lsu_patterns.txt
# op lsb size b_sel rs2 imm rdata delay expected, all hex
# op 0 load 1 store 2 shift; expected is wdata, o_q stream or cycles to done
1 0 2 1 a1b2c3d4 11111111 00000000 0 a1b2c3d4
1 1 0 1 12345678 00000000 00000000 1 34567800
1 2 1 0 00000000 cafef00d 00000000 2 f00d0000
1 3 0 1 deadbeef 00000000 00000000 3 ef000000
1 0 1 0 00000000 89abcdef 00000000 0 89abcdef
1 1 1 1 0f1e2d3c 00000000 00000000 5 1e2d3c00
1 2 2 0 00000000 55aa33cc 00000000 0 33cc0000
0 0 2 1 00000000 00000000 87654321 0 87654321
0 1 2 0 00000000 00000000 87654321 1 00876543
0 2 1 1 00000000 00000000 fedcba98 4 0000fedc
0 3 0 0 00000000 00000000 fedcba98 0 000000fe
0 0 0 1 00000000 00000000 00ff00ff 7 00ff00ff
0 1 0 1 00000000 00000000 ffffffff 2 00ffffff
2 0 2 1 ffffffe0 00000000 00000000 0 2
2 0 2 0 00000000 00000001 00000000 0 3
2 0 2 1 00000031 00000000 00000000 0 13
2 0 2 0 00000000 7777777f 00000000 0 21
2 0 2 1 0000001f 00000000 00000000 0 21
2 0 2 0 00000000 00000011 00000000 0 13
2 0 2 1 00000001 00000000 00000000 0 3
2 0 2 0 00000000 ffffffe0 00000000 0 2

// File: testbench/tb_ser_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ser_lsu;
   import ser_pkg::*;

   localparam int MAX_PATS   = 64;
   localparam int WAIT_LIMIT = 100;   // cycles allowed for any phase.

   typedef struct packed {
      cmd_t       cmd;
      word_t      rs2;
      word_t      imm;
      word_t      rdata;      // memory answer for loads.
      logic [7:0] delay;      // cycles before the ack.
      word_t      expected;   // wdata, o_q stream or cycle count.
   } pattern_t;

   logic     clk;
   logic     rst;
   logic     start;
   cmd_t     cmd;
   logic     rs2;
   logic     imm;
   logic     mem_ack;
   word_t    mem_rdata;
   logic     busy;
   logic     init;
   logic     run;
   logic     q;
   logic     done;
   logic     mem_req;
   mem_req_t mem;

   pattern_t pats [MAX_PATS];
   int       n_pats = 0;

   ser_lsu_top uut (
      .i_clk       (clk),
      .i_rst       (rst),
      .i_start     (start),
      .i_cmd       (cmd),
      .i_rs2       (rs2),
      .i_imm       (imm),
      .i_mem_ack   (mem_ack),
      .i_mem_rdata (mem_rdata),
      .o_busy      (busy),
      .o_init      (init),
      .o_run       (run),
      .o_q         (q),
      .o_done      (done),
      .o_mem_req   (mem_req),
      .o_mem       (mem)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns.
   end

   task automatic stop_run();
      $display("TESTS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_sel(input string name, input sel_t got, input sel_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         stop_run();
      end
   endtask

   // bytes covered by the size, from lsb up, cut at lane 3.
   function automatic sel_t lanes_for(input lsb_t lsb, input size_e size);
      int   nbytes;
      int   k;
      sel_t s;
      nbytes = (size == SZ_BYTE) ? 1 : (size == SZ_HALF) ? 2 : 4;
      s = '0;
      for (k = 0; k < 4; k++) begin
         if (k >= int'(lsb) && k < int'(lsb) + nbytes) s[k] = 1'b1;
      end
      return s;
   endfunction

   // lanes at and above lsb carry store data.
   function automatic word_t lane_mask(input lsb_t lsb);
      int    k;
      word_t m;
      m = '0;
      for (k = int'(lsb); k < 4; k++) m[8*k +: 8] = 8'hff;
      return m;
   endfunction

   task automatic read_patterns();
      int    fd;
      int    rc;
      string line;
      int    op;
      int    lsb;
      int    size;
      int    bsel;
      int    dly;
      word_t v_rs2;
      word_t v_imm;
      word_t v_rdata;
      word_t v_exp;
      fd = $fopen("testbench/ser_lsu_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open the pattern file");
         stop_run();
      end
      while (!$feof(fd) && n_pats < MAX_PATS) begin
         line = "";
         rc = $fgets(line, fd);
         if (rc > 1 && line[0] != 8'h23) begin   // skip blanks and # lines.
            rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h", op, lsb, size, bsel,
                         v_rs2, v_imm, v_rdata, dly, v_exp);
            if (rc == 9) begin
               pats[n_pats].cmd.op    = op_e'(op[1:0]);
               pats[n_pats].cmd.lsb   = lsb[1:0];
               pats[n_pats].cmd.size  = size_e'(size[1:0]);
               pats[n_pats].cmd.b_sel = bsel[0];
               pats[n_pats].rs2       = v_rs2;
               pats[n_pats].imm       = v_imm;
               pats[n_pats].rdata     = v_rdata;
               pats[n_pats].delay     = dly[7:0];
               pats[n_pats].expected  = v_exp;
               n_pats++;
            end
         end
      end
      $fclose(fd);
      if (n_pats == 0) begin
         $display("pattern file holds no usable lines");
         stop_run();
      end
   endtask

   task automatic pulse_start(input cmd_t c);
      @(posedge clk);
      start <= 1'b1;
      cmd   <= c;
      @(posedge clk);
      start <= 1'b0;   // phase starts now.
   endtask

   task automatic wait_done();
      int waited;
      waited = 0;
      @(negedge clk);
      check_flag("o_busy", busy, 1'b1);   // busy up to and with done.
      while (!done) begin
         waited++;
         if (waited > WAIT_LIMIT) begin
            $display("o_done never came after the operation");
            stop_run();
         end
         @(negedge clk);
         check_flag("o_busy", busy, 1'b1);
      end
   endtask

   task automatic run_command(input pattern_t p);
      int       i;
      int       waited;
      word_t    got;
      mem_req_t seen;
      pulse_start(p.cmd);
      if (p.cmd.op != OP_LOAD) begin
         for (i = 0; i < XLEN; i++) begin
            rs2 <= p.rs2[i];   // lsb first.
            imm <= p.imm[i];
            @(negedge clk);
            if (!init) begin
               $display("o_init low during operand shift-in");
               stop_run();
            end
            @(posedge clk);
         end
         rs2 <= 1'b0;   // zero fill from here on.
         imm <= 1'b0;
      end
      if (p.cmd.op == OP_SHIFT) begin
         waited = 0;   // cycles since the last init cycle.
         do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
               $display("shift never finished counting");
               stop_run();
            end
         end while (!done);
         check_count("shift cycles to o_done", waited, int'(p.expected));
         return;
      end
      waited = 0;
      @(negedge clk);
      while (!mem_req) begin
         waited++;
         if (waited > WAIT_LIMIT) begin
            $display("memory request never raised");
            stop_run();
         end
         @(negedge clk);
      end
      seen = mem;
      check_flag("o_mem.we", seen.we, p.cmd.op == OP_STORE);
      if (p.cmd.op == OP_STORE) begin
         check_sel("o_mem.sel", seen.sel, lanes_for(p.cmd.lsb, p.cmd.size));
         check_word("o_mem.wdata", seen.wdata & lane_mask(p.cmd.lsb),
                    p.expected & lane_mask(p.cmd.lsb));
      end
      repeat (p.delay) begin
         @(negedge clk);
         check_flag("o_mem_req held", mem_req, 1'b1);
         check_word("o_mem.wdata held", mem.wdata, seen.wdata);
         check_sel("o_mem.sel held", mem.sel, seen.sel);
      end
      @(posedge clk);
      mem_ack   <= 1'b1;
      mem_rdata <= p.rdata;
      @(negedge clk);
      check_flag("o_mem_req at ack", mem_req, 1'b1);
      @(posedge clk);
      mem_ack   <= 1'b0;
      mem_rdata <= '0;
      if (p.cmd.op == OP_LOAD) begin
         got = '0;
         for (i = 0; i < XLEN; i++) begin
            @(negedge clk);
            if (!run) begin
               $display("o_run low during load read-out");
               stop_run();
            end
            got[i] = q;
         end
         check_word("o_q stream", got, p.expected);
      end
      wait_done();
   endtask

   // abort a command partway, then confirm everything is idle.
   task automatic reset_during(input pattern_t p, input int cycles_in);
      pulse_start(p.cmd);
      repeat (cycles_in) @(posedge clk);
      rst <= 1'b1;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_flag("o_busy after reset", busy, 1'b0);
      check_flag("o_init after reset", init, 1'b0);
      check_flag("o_run after reset", run, 1'b0);
      check_flag("o_done after reset", done, 1'b0);
      check_flag("o_mem_req after reset", mem_req, 1'b0);
   endtask

   // watchdog, 200 cycles per pattern line.
   initial begin
      wait (n_pats > 0);
      repeat (n_pats * 200) @(posedge clk);
      $display("watchdog expired before all commands finished");
      stop_run();
   end

   initial begin
      int i;
      rst       = 1'b1;
      start     = 1'b0;
      cmd       = '0;
      rs2       = 1'b0;
      imm       = 1'b0;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      void'($urandom(24));
      read_patterns();
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      for (i = 0; i < n_pats; i++) begin
         repeat ($urandom_range(3)) @(posedge clk);   // idle gap.
         run_command(pats[i]);
      end
      // mid-init store, then a pending load request.
      for (i = 0; i < n_pats; i++) begin
         if (pats[i].cmd.op != OP_SHIFT) begin
            reset_during(pats[i], (pats[i].cmd.op == OP_STORE) ? 10 : 3);
            run_command(pats[i]);
         end
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
